//--- Bender.yml
package:
  name: planning

sources:
  - grid_pkg.sv
  - genbuf_pkg.sv
  - move_decode.sv
  - maint_counter.sv
  - grid_execute.sv
  - sender_monitor.sv
  - collision_result.sv
  - planning_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_planning.sv

//--- collision_result.sv
`timescale 1ns/1ps

module collision_result (
  input  logic           clk,
  input  logic           i_rst_n,
  input  logic           i_robot_go,
  input  logic           i_obs_go,
  input  grid_pkg::pos_t i_robot_pos,
  input  grid_pkg::pos_t i_obs_pos,
  output logic           o_error
);

  logic excl_q;
  logic error_q;
  logic cur_excl;
  logic coll;

  // Robot and obstacle did not both move this cycle
  assign cur_excl = ~(i_robot_go & i_obs_go);
  assign coll     = (i_robot_pos == i_obs_pos);

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      excl_q  <= 1'b1;
      error_q <= 1'b0;
    end
    else
    begin
      // Once a joint move happened the run is no longer exclusive
      excl_q  <= excl_q & cur_excl;
      error_q <= error_q | (excl_q & cur_excl & coll);
    end
  end

  assign o_error = error_q;

endmodule

//--- compile.f
grid_pkg.sv
genbuf_pkg.sv
move_decode.sv
maint_counter.sv
grid_execute.sv
sender_monitor.sv
collision_result.sv
planning_top.sv
tb_clock_gen.sv
tb_planning.sv

//--- genbuf_pkg.sv
package genbuf_pkg;

  // ==========================================================
  // Sender side of the buffer handshake
  // ==========================================================

  // Senders talking four-phase req/ack to the buffer
  localparam int N_SENDERS = 3;

  // One bit per sender, used for both req and ack
  typedef logic [N_SENDERS-1:0] sender_vec_t;

endpackage

//--- grid_execute.sv
`timescale 1ns/1ps

module grid_execute #(
  parameter grid_pkg::coord_t P_GRID_MAX = grid_pkg::GRID_MAX_DEF
) (
  input  logic           clk,
  input  logic           i_rst_n,
  input  logic           i_robot_go,
  input  logic [3:0]     i_robot_step,
  input  logic           i_obs_vert_up,
  input  logic           i_obs_vert_down,
  input  logic           i_obs_horz_left,
  input  logic           i_obs_horz_right,
  input  logic           i_obs_go,
  input  logic           i_maintenance,
  input  logic           i_shock,
  output grid_pkg::pos_t o_robot_pos,
  output grid_pkg::pos_t o_obs_pos
);

  import grid_pkg::*;

  pos_t robot_q;
  pos_t obs_q;
  logic robot_en;
  logic obs_en;

  assign robot_en = i_robot_go & ~i_shock;
  assign obs_en   = i_obs_go & ~i_maintenance;

  // ==========================================================
  // Obstacle moves one cell per axis and drops blocked steps
  // ==========================================================
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      obs_q.x <= OBS_START_X;
      obs_q.y <= '0;
    end
    else if (obs_en)
    begin
      if (i_obs_vert_up && obs_q.y < P_GRID_MAX)
        obs_q.y <= obs_q.y + 1'b1;
      else if (i_obs_vert_down && obs_q.y != '0)
        obs_q.y <= obs_q.y - 1'b1;
      if (i_obs_horz_left && obs_q.x != '0)
        obs_q.x <= obs_q.x - 1'b1;
      else if (i_obs_horz_right && obs_q.x < P_GRID_MAX)
        obs_q.x <= obs_q.x + 1'b1;
    end
  end

  // ==========================================================
  // Robot takes the first direction not blocked by a wall
  // ==========================================================
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      robot_q <= '0;
    else if (robot_en)
    begin
      if (i_robot_step[3] && robot_q.y != '0)
        robot_q.y <= robot_q.y - 1'b1;
      else if (i_robot_step[2] && robot_q.y < P_GRID_MAX)
        robot_q.y <= robot_q.y + 1'b1;
      else if (i_robot_step[1] && robot_q.x != '0)
        robot_q.x <= robot_q.x - 1'b1;
      else if (i_robot_step[0] && robot_q.x < P_GRID_MAX)
        robot_q.x <= robot_q.x + 1'b1;
    end
  end

  assign o_robot_pos = robot_q;
  assign o_obs_pos   = obs_q;

endmodule

//--- grid_pkg.sv
package grid_pkg;

  // ==========================================================
  // Grid geometry
  // ==========================================================

  // One coordinate on the square grid
  typedef logic [3:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } pos_t;

  // Grid side is three times k cells
  localparam int     GRID_K       = 2;
  localparam coord_t GRID_MAX_DEF = coord_t'(3 * GRID_K - 1);
  localparam coord_t OBS_START_X  = 4'd2;

  // ==========================================================
  // Move commands and maintenance
  // ==========================================================

  typedef struct packed {
    logic move;
    logic up;
    logic down;
    logic left;
    logic right;
  } robot_cmd_t;

  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
  } obs_cmd_t;

  // Counts 0 to 32 inclusive before wrapping
  typedef logic [5:0] maint_cnt_t;
  localparam maint_cnt_t MAINT_WRAP = 6'd32;

endpackage

//--- maint_counter.sv
`timescale 1ns/1ps

module maint_counter #(
  parameter int unsigned P_MAINT_BIT = 2
) (
  input  logic clk,
  input  logic i_rst_n,
  input  logic i_obs_go,
  output logic o_maintenance
);

  import grid_pkg::*;

  maint_cnt_t cnt_q;

  // One count per obstacle move, back to zero after the wrap value
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      cnt_q <= '0;
    else if (i_obs_go)
    begin
      if (cnt_q < MAINT_WRAP)
        cnt_q <= cnt_q + 1'b1;
      else
        cnt_q <= '0;
    end
  end

  assign o_maintenance = cnt_q[P_MAINT_BIT];

endmodule

//--- move_decode.sv
`timescale 1ns/1ps

module move_decode (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  grid_pkg::robot_cmd_t i_robot_cmd,
  input  grid_pkg::obs_cmd_t   i_obs_cmd,
  input  logic                 i_error,
  output logic                 o_robot_go,
  output logic                 o_obs_go,
  output logic [3:0]           o_robot_step,
  output logic                 o_obs_vert_up,
  output logic                 o_obs_vert_down,
  output logic                 o_obs_horz_left,
  output logic                 o_obs_horz_right
);

  logic not_first_q;
  logic move_allowed;
  logic obs_any;

  // Cleared by reset, set from the first edge on
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      not_first_q <= 1'b0;
    else
      not_first_q <= 1'b1;
  end

  // Nothing moves on the very first step or once the error is up
  assign move_allowed = not_first_q & ~i_error;

  assign obs_any = i_obs_cmd.up | i_obs_cmd.down | i_obs_cmd.left | i_obs_cmd.right;

  assign o_robot_go = move_allowed & i_robot_cmd.move;
  assign o_obs_go   = move_allowed & obs_any;

  // Robot requests go MSB first in the priority order down, up, left, right
  // The executor falls through to the next bit when a wall blocks one
  assign o_robot_step = o_robot_go ? {i_robot_cmd.down, i_robot_cmd.up,
                                      i_robot_cmd.left, i_robot_cmd.right} : 4'b0000;

  // Each obstacle axis resolves on its own
  assign o_obs_vert_up    = i_obs_cmd.up;
  assign o_obs_vert_down  = i_obs_cmd.down & ~i_obs_cmd.up;
  assign o_obs_horz_left  = i_obs_cmd.left;
  assign o_obs_horz_right = i_obs_cmd.right & ~i_obs_cmd.left;

endmodule

//--- planning_top.sv
`timescale 1ns/1ps

module planning_top #(
  parameter grid_pkg::coord_t P_GRID_MAX  = grid_pkg::GRID_MAX_DEF,
  parameter int unsigned      P_MAINT_BIT = 2
) (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  grid_pkg::robot_cmd_t    i_robot_cmd,
  input  grid_pkg::obs_cmd_t      i_obs_cmd,
  input  genbuf_pkg::sender_vec_t i_sender_req,
  input  genbuf_pkg::sender_vec_t i_sender_ack,
  output logic                    o_rt_robot,
  output logic                    o_rt_obs,
  output logic                    o_error,
  output grid_pkg::pos_t          o_robot_pos,
  output grid_pkg::pos_t          o_obs_pos
);

  import grid_pkg::*;

  logic       robot_go;
  logic       obs_go;
  logic [3:0] robot_step;
  logic       obs_vert_up;
  logic       obs_vert_down;
  logic       obs_horz_left;
  logic       obs_horz_right;
  logic       maintenance;
  logic       shock;
  logic       error;
  pos_t       robot_pos;
  pos_t       obs_pos;

  // ==========================================================
  // Decode, execute, result
  // ==========================================================
  move_decode u_move_decode (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_robot_cmd      (i_robot_cmd),
    .i_obs_cmd        (i_obs_cmd),
    .i_error          (error),
    .o_robot_go       (robot_go),
    .o_obs_go         (obs_go),
    .o_robot_step     (robot_step),
    .o_obs_vert_up    (obs_vert_up),
    .o_obs_vert_down  (obs_vert_down),
    .o_obs_horz_left  (obs_horz_left),
    .o_obs_horz_right (obs_horz_right)
  );

  grid_execute #(
    .P_GRID_MAX (P_GRID_MAX)
  ) u_grid_execute (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_robot_go       (robot_go),
    .i_robot_step     (robot_step),
    .i_obs_vert_up    (obs_vert_up),
    .i_obs_vert_down  (obs_vert_down),
    .i_obs_horz_left  (obs_horz_left),
    .i_obs_horz_right (obs_horz_right),
    .i_obs_go         (obs_go),
    .i_maintenance    (maintenance),
    .i_shock          (shock),
    .o_robot_pos      (robot_pos),
    .o_obs_pos        (obs_pos)
  );

  collision_result u_collision_result (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_robot_go  (robot_go),
    .i_obs_go    (obs_go),
    .i_robot_pos (robot_pos),
    .i_obs_pos   (obs_pos),
    .o_error     (error)
  );

  // Freeze sources for the obstacle and the robot
  maint_counter #(
    .P_MAINT_BIT (P_MAINT_BIT)
  ) u_maint_counter (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_obs_go      (obs_go),
    .o_maintenance (maintenance)
  );

  sender_monitor u_sender_monitor (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_sender_req (i_sender_req),
    .i_sender_ack (i_sender_ack),
    .o_shock      (shock)
  );

  assign o_rt_robot  = robot_go;
  assign o_rt_obs    = obs_go;
  assign o_error     = error;
  assign o_robot_pos = robot_pos;
  assign o_obs_pos   = obs_pos;

endmodule

//--- sender_monitor.sv
`timescale 1ns/1ps

module sender_monitor (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  genbuf_pkg::sender_vec_t i_sender_req,
  input  genbuf_pkg::sender_vec_t i_sender_ack,
  output logic                    o_shock
);

  import genbuf_pkg::*;

  sender_vec_t req_q;
  sender_vec_t ack_q;
  logic        env_err_seen_q;

  sender_vec_t env_hold_err;
  sender_vec_t env_drop_err;
  sender_vec_t sys_rise_err;
  sender_vec_t sys_idle_err;
  sender_vec_t sys_hold_err;
  logic        ack_overlap;
  logic        env_err;
  logic        sys_err;

  // ==========================================================
  // Environment rules, on the senders
  // ==========================================================

  // Request withdrawn before it was acknowledged
  assign env_hold_err = req_q & ~ack_q & ~i_sender_req;
  // Request still up the cycle after an acknowledge
  assign env_drop_err = ack_q & i_sender_req;

  // ==========================================================
  // System rules, on the buffer acknowledges
  // ==========================================================

  // Ack in the same cycle the request rises
  assign sys_rise_err = ~req_q & i_sender_req & i_sender_ack;
  // Ack rising out of the idle phase
  assign sys_idle_err = ~req_q & ~ack_q & i_sender_ack;
  // Ack dropped while its request is still held
  assign sys_hold_err = req_q & ack_q & ~i_sender_ack;

  // At most one sender acknowledged at a time
  always_comb
  begin
    ack_overlap = 1'b0;
    for (int i = 0; i < N_SENDERS; i++)
      for (int j = i + 1; j < N_SENDERS; j++)
        ack_overlap = ack_overlap | (i_sender_ack[i] & i_sender_ack[j]);
  end

  assign env_err = |(env_hold_err | env_drop_err);
  assign sys_err = |(sys_rise_err | sys_idle_err | sys_hold_err) | ack_overlap;

  // Only the buffer is blamed, and only while the senders never misbehaved
  assign o_shock = sys_err & ~env_err & ~env_err_seen_q;

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      req_q          <= '0;
      ack_q          <= '0;
      env_err_seen_q <= 1'b0;
    end
    else
    begin
      req_q          <= i_sender_req;
      ack_q          <= i_sender_ack;
      env_err_seen_q <= env_err_seen_q | env_err;
    end
  end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int P_HALF_NS    = 20,
  parameter int P_RST_CYCLES = 5
) (
  output logic clk,
  output logic o_rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(P_HALF_NS) clk = ~clk;
  end

  // Reset low for a fixed number of rising edges
  initial
  begin
    o_rst_n = 1'b0;
    repeat (P_RST_CYCLES) @(posedge clk);
    o_rst_n <= 1'b1;
  end

endmodule

//--- tb_planning.sv
`timescale 1ns/1ps

module tb_planning;

  import grid_pkg::*;
  import genbuf_pkg::*;

  localparam coord_t GRID_MAX  = 4'd5;
  localparam int     MAINT_BIT = 2;
  localparam int     N_LEGAL   = 100;
  localparam int     N_VIOL    = 60;
  localparam int     N_ENV     = 60;
  localparam int     N_WALK    = 30;
  // Reset, drain and walk overheads on top of the random phases
  localparam int     N_CYCLES  = 5 + 2 + N_LEGAL + 4 + N_VIOL + 2 + N_ENV + 4 + 4 + N_WALK + 1;

  logic        clk;
  logic        gen_rst_n;
  logic        run_rst_n;
  logic        rst_n;
  robot_cmd_t  robot_cmd;
  obs_cmd_t    obs_cmd;
  sender_vec_t sender_req;
  sender_vec_t sender_ack;
  logic        rt_robot;
  logic        rt_obs;
  logic        coll_error;
  pos_t        robot_pos;
  pos_t        obs_pos;

  integer      seed;
  int          snd_phase [N_SENDERS];
  int          shock_hits = 0;
  int          frozen_obs_hits = 0;

  // Model state
  logic        m_not_first;
  logic        m_excl;
  logic        m_err;
  logic        m_env_seen;
  logic [5:0]  m_cnt;
  pos_t        m_robot;
  pos_t        m_obs;
  sender_vec_t m_req_q;
  sender_vec_t m_ack_q;
  logic        m_rgo;
  logic        m_ogo;
  logic        m_sys_bad;
  logic        m_env_bad;
  logic        m_shock;

  tb_clock_gen #(
    .P_HALF_NS    (20),
    .P_RST_CYCLES (5)
  ) u_clock_gen (
    .clk     (clk),
    .o_rst_n (gen_rst_n)
  );

  // Second reset source lets the collision walk start from a fresh run
  assign rst_n = gen_rst_n & run_rst_n;

  planning_top #(
    .P_GRID_MAX  (GRID_MAX),
    .P_MAINT_BIT (MAINT_BIT)
  ) u_planning_top (
    .clk          (clk),
    .i_rst_n      (rst_n),
    .i_robot_cmd  (robot_cmd),
    .i_obs_cmd    (obs_cmd),
    .i_sender_req (sender_req),
    .i_sender_ack (sender_ack),
    .o_rt_robot   (rt_robot),
    .o_rt_obs     (rt_obs),
    .o_error      (coll_error),
    .o_robot_pos  (robot_pos),
    .o_obs_pos    (obs_pos)
  );

  // ==========================================================
  // Reference model
  // ==========================================================

  // Priority down, up, left, right with fall-through past a blocked direction
  function automatic pos_t robot_next(input pos_t p, input robot_cmd_t c);
    pos_t n;
    n = p;
    if (c.down && p.y > 0)
      n.y = p.y - 1;
    else if (c.up && p.y < GRID_MAX)
      n.y = p.y + 1;
    else if (c.left && p.x > 0)
      n.x = p.x - 1;
    else if (c.right && p.x < GRID_MAX)
      n.x = p.x + 1;
    return n;
  endfunction

  // Each axis resolves on its own with up over down and left over right
  function automatic pos_t obs_next(input pos_t p, input obs_cmd_t c);
    pos_t n;
    n = p;
    if (c.up)
    begin
      if (p.y < GRID_MAX)
        n.y = p.y + 1;
    end
    else if (c.down && p.y > 0)
      n.y = p.y - 1;
    if (c.left)
    begin
      if (p.x > 0)
        n.x = p.x - 1;
    end
    else if (c.right && p.x < GRID_MAX)
      n.x = p.x + 1;
    return n;
  endfunction

  always_comb
  begin
    m_rgo     = m_not_first && !m_err && robot_cmd.move;
    m_ogo     = m_not_first && !m_err && (obs_cmd != '0);
    m_sys_bad = ($countones(sender_ack) > 1);
    m_env_bad = 1'b0;
    for (int s = 0; s < N_SENDERS; s++)
    begin
      // Senders hold a request until acked and drop it right after
      m_env_bad = m_env_bad | (m_req_q[s] & ~m_ack_q[s] & ~sender_req[s]);
      m_env_bad = m_env_bad | (m_ack_q[s] & sender_req[s]);
      // Buffer acks neither early, nor from idle, nor drop while held
      m_sys_bad = m_sys_bad | (~m_req_q[s] & sender_req[s] & sender_ack[s]);
      m_sys_bad = m_sys_bad | (~m_req_q[s] & ~m_ack_q[s] & sender_ack[s]);
      m_sys_bad = m_sys_bad | (m_req_q[s] & m_ack_q[s] & ~sender_ack[s]);
    end
    m_shock = m_sys_bad && !m_env_bad && !m_env_seen;
  end

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      m_not_first <= 1'b0;
      m_excl      <= 1'b1;
      m_err       <= 1'b0;
      m_env_seen  <= 1'b0;
      m_cnt       <= '0;
      m_robot     <= '{x: 4'd0, y: 4'd0};
      m_obs       <= '{x: 4'd2, y: 4'd0};
      m_req_q     <= '0;
      m_ack_q     <= '0;
    end
    else
    begin
      m_not_first <= 1'b1;
      if (m_rgo && !m_shock)
        m_robot <= robot_next(m_robot, robot_cmd);
      if (m_ogo && !m_cnt[MAINT_BIT])
        m_obs <= obs_next(m_obs, obs_cmd);
      if (m_ogo)
        m_cnt <= (m_cnt >= 6'd32) ? 6'd0 : m_cnt + 6'd1;
      m_excl <= m_excl && !(m_rgo && m_ogo);
      if (m_excl && !(m_rgo && m_ogo) && m_robot == m_obs)
        m_err <= 1'b1;
      m_req_q <= sender_req;
      m_ack_q <= sender_ack;
      if (m_env_bad)
        m_env_seen <= 1'b1;
      if (m_rgo && m_shock)
        shock_hits++;
      if (m_ogo && m_cnt[MAINT_BIT])
        frozen_obs_hits++;
    end
  end

  // ==========================================================
  // Checking
  // ==========================================================

  task automatic report_mismatch(input string name, input logic [7:0] dut_val,
                                 input logic [7:0] exp_val);
    $display("MISMATCH at %0t: %s dut=%0h expected=%0h", $time, name, dut_val, exp_val);
    $display("STATUS: FAIL");
    $fatal(1, "output check failed");
  endtask

  task automatic report_failure(input string what);
    $display("ERROR at %0t: %s", $time, what);
    $display("STATUS: FAIL");
    $fatal(1, "run check failed");
  endtask

  // Outputs are compared mid-cycle, well away from the driving edge
  always @(negedge clk)
  begin
    if (rst_n === 1'b1)
    begin
      assert (robot_pos.x <= GRID_MAX && robot_pos.y <= GRID_MAX)
        else report_failure("robot position left the grid");
      assert (rt_robot === m_rgo)
        else report_mismatch("o_rt_robot", 8'(rt_robot), 8'(m_rgo));
      assert (rt_obs === m_ogo)
        else report_mismatch("o_rt_obs", 8'(rt_obs), 8'(m_ogo));
      assert (coll_error === m_err)
        else report_mismatch("o_error", 8'(coll_error), 8'(m_err));
      assert (robot_pos === m_robot)
        else report_mismatch("o_robot_pos", robot_pos, m_robot);
      assert (obs_pos === m_obs)
        else report_mismatch("o_obs_pos", obs_pos, m_obs);
    end
  end

  // ==========================================================
  // Stimulus
  // ==========================================================

  function automatic sender_vec_t rand_vec();
    logic [31:0] r;
    r = $random(seed);
    return r[N_SENDERS-1:0];
  endfunction

  task automatic drive_random_moves();
    logic [31:0] r;
    r = $random(seed);
    robot_cmd <= r[4:0];
    obs_cmd   <= r[11:8];
  endtask

  function automatic logic senders_busy();
    logic busy;
    busy = 1'b0;
    for (int s = 0; s < N_SENDERS; s++)
      busy = busy | (snd_phase[s] != 0);
    return busy;
  endfunction

  // Sender phase 0 is idle, 1 requests, 2 is acked and 3 is the ack tail after the drop
  task automatic drive_legal_senders(input logic allow_new);
    logic        granted;
    sender_vec_t nreq;
    sender_vec_t nack;
    granted = 1'b0;
    for (int s = 0; s < N_SENDERS; s++)
      granted = granted | (snd_phase[s] == 2);
    for (int s = 0; s < N_SENDERS; s++)
    begin
      case (snd_phase[s])
        0:
        begin
          if (allow_new && (($random(seed) & 3) == 0))
            snd_phase[s] = 1;
        end
        1:
        begin
          if (!granted && (($random(seed) & 1) == 0))
          begin
            snd_phase[s] = 2;
            granted      = 1'b1;
          end
        end
        2: snd_phase[s] = 3;
        default: snd_phase[s] = 0;
      endcase
      nreq[s] = (snd_phase[s] == 1) || (snd_phase[s] == 2);
      nack[s] = (snd_phase[s] == 2) || (snd_phase[s] == 3);
    end
    sender_req <= nreq;
    sender_ack <= nack;
  endtask

  initial
  begin
    seed       = 78532;
    run_rst_n  = 1'b1;
    robot_cmd  = 5'b11000;
    obs_cmd    = 4'b1000;
    sender_req = '0;
    sender_ack = '0;
    for (int s = 0; s < N_SENDERS; s++)
      snd_phase[s] = 0;
    wait (rst_n === 1'b1);
    // First step is gated, the second is a joint move that ends exclusivity
    repeat (2) @(posedge clk);

    // Legal sender traffic
    repeat (N_LEGAL)
    begin
      @(posedge clk);
      drive_random_moves();
      drive_legal_senders(1'b1);
    end
    while (senders_busy())
    begin
      @(posedge clk);
      drive_random_moves();
      drive_legal_senders(1'b0);
    end

    // Stray acks with every request low
    repeat (N_VIOL)
    begin
      @(posedge clk);
      drive_random_moves();
      sender_ack <= rand_vec();
    end

    // Request withdrawn without an ack, then free traffic
    @(posedge clk);
    sender_req <= 3'b001;
    sender_ack <= '0;
    @(posedge clk);
    sender_req <= '0;
    repeat (N_ENV)
    begin
      @(posedge clk);
      drive_random_moves();
      sender_req <= rand_vec();
      sender_ack <= rand_vec();
    end

    // Fresh run in which the robot walks right into the parked obstacle
    @(posedge clk);
    run_rst_n  <= 1'b0;
    robot_cmd  <= '0;
    obs_cmd    <= '0;
    sender_req <= '0;
    sender_ack <= '0;
    repeat (3) @(posedge clk);
    run_rst_n <= 1'b1;
    robot_cmd <= 5'b10001;
    repeat (4) @(posedge clk);
    repeat (N_WALK)
    begin
      @(posedge clk);
      drive_random_moves();
    end

    @(negedge clk);
    assert (coll_error === 1'b1) else report_failure("collision walk did not raise the error");
    assert (shock_hits > 0) else report_failure("shock never froze a robot move");
    assert (frozen_obs_hits > 0) else report_failure("maintenance never froze the obstacle");
    $display("STATUS: PASS");
    $finish;
  end

  initial
  begin
    #((N_CYCLES + 50) * 40);
    $display("ERROR: watchdog expired before the test sequence finished");
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

endmodule
